// ==== hdl/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath width in bits
`define EXEC_XLEN 32

// Architectural registers, x0 included
`define EXEC_NUM_REGS 32

// Issue queue entries, equal to the sender credits after reset
`define EXEC_QUEUE_DEPTH 4

// Cycles from multiplier accept to result valid
`define EXEC_MUL_LATENCY 3

`endif

// ==== hdl/exec_pkg.sv ====
`default_nettype none

`include "exec_config.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0] xlen_t;
    typedef logic [$clog2(`EXEC_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        OP_MUL  = 4'd10
    } op_e;

    // Owner of a stage's result
    typedef enum logic {
        FU_ALU,
        FU_MUL
    } func_unit_e;

    function automatic func_unit_e unit_of_op(op_e op);
        return (op == OP_MUL) ? FU_MUL : FU_ALU;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module issue_queue (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                in_valid_i,
    input  exec_pkg::op_e       in_op_i,
    input  exec_pkg::reg_idx_t  in_rd_i,
    input  exec_pkg::reg_idx_t  in_rs1_i,
    input  exec_pkg::reg_idx_t  in_rs2_i,
    input  exec_pkg::xlen_t     in_imm_i,
    input  logic                in_use_imm_i,
    input  logic                issue_i,
    output logic                head_valid_o,
    output exec_pkg::op_e       head_op_o,
    output exec_pkg::reg_idx_t  head_rd_o,
    output exec_pkg::reg_idx_t  head_rs1_o,
    output exec_pkg::reg_idx_t  head_rs2_o,
    output exec_pkg::xlen_t     head_imm_o,
    output logic                head_use_imm_o,
    output logic                credit_o
);

    import exec_pkg::*;

    localparam int DEPTH = `EXEC_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    op_e      op_q      [DEPTH];
    reg_idx_t rd_q      [DEPTH];
    reg_idx_t rs1_q     [DEPTH];
    reg_idx_t rs2_q     [DEPTH];
    xlen_t    imm_q     [DEPTH];
    logic     use_imm_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_valid_o = (count_q != '0);
    assign pop          = issue_i && head_valid_o;

    // Every instruction leaving the queue hands one credit back
    assign credit_o = pop;

    // No full check here, the sender never pushes without a credit
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (in_valid_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({in_valid_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            op_q[wr_ptr_q]      <= in_op_i;
            rd_q[wr_ptr_q]      <= in_rd_i;
            rs1_q[wr_ptr_q]     <= in_rs1_i;
            rs2_q[wr_ptr_q]     <= in_rs2_i;
            imm_q[wr_ptr_q]     <= in_imm_i;
            use_imm_q[wr_ptr_q] <= in_use_imm_i;
        end
    end

    assign head_op_o      = op_q[rd_ptr_q];
    assign head_rd_o      = rd_q[rd_ptr_q];
    assign head_rs1_o     = rs1_q[rd_ptr_q];
    assign head_rs2_o     = rs2_q[rd_ptr_q];
    assign head_imm_o     = imm_q[rd_ptr_q];
    assign head_use_imm_o = use_imm_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module reg_file (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  exec_pkg::reg_idx_t  ra_sel_i,
    input  exec_pkg::reg_idx_t  rb_sel_i,
    output exec_pkg::xlen_t     ra_data_o,
    output exec_pkg::xlen_t     rb_data_o,
    input  logic                w_en_i,
    input  exec_pkg::reg_idx_t  w_sel_i,
    input  exec_pkg::xlen_t     w_data_i
);

    import exec_pkg::*;

    xlen_t regs_q [`EXEC_NUM_REGS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (w_en_i && w_sel_i != '0) begin
            regs_q[w_sel_i] <= w_data_i;
        end
    end

    // x0 is hard-wired, same-cycle writes are covered by EX2 forwarding
    assign ra_data_o = (ra_sel_i == '0) ? '0 : regs_q[ra_sel_i];
    assign rb_data_o = (rb_sel_i == '0) ? '0 : regs_q[rb_sel_i];

endmodule

`default_nettype wire

// ==== hdl/hazard_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_bypass (
    input  logic                head_valid_i,
    input  exec_pkg::op_e       head_op_i,
    input  exec_pkg::reg_idx_t  head_rs1_i,
    input  exec_pkg::reg_idx_t  head_rs2_i,
    input  exec_pkg::xlen_t     ra_data_i,
    input  exec_pkg::xlen_t     rb_data_i,
    input  logic                ex1_pending_i,
    input  logic                ex1_data_valid_i,
    input  exec_pkg::reg_idx_t  ex1_rd_i,
    input  exec_pkg::xlen_t     ex1_data_i,
    input  logic                ex2_pending_i,
    input  logic                ex2_data_valid_i,
    input  exec_pkg::reg_idx_t  ex2_rd_i,
    input  exec_pkg::xlen_t     ex2_data_i,
    input  logic                ex1_ready_i,
    input  logic                mul_ready_i,
    output exec_pkg::xlen_t     rs1_value_o,
    output exec_pkg::xlen_t     rs2_value_o,
    output logic                issue_o
);

    import exec_pkg::*;

    logic rs1_hazard;
    logic rs2_hazard;
    logic struct_hazard;

    // Returns {hazard, value} for one source register
    // EX1 holds the newer instruction, so it is looked at first
    function automatic logic [$bits(xlen_t):0] bypass(reg_idx_t rs, xlen_t rf_value);
        logic  hazard;
        xlen_t value;
        hazard = 1'b0;
        value  = rf_value;
        if (rs != '0) begin
            if (ex1_pending_i && ex1_rd_i == rs) begin
                if (ex1_data_valid_i) begin
                    value = ex1_data_i;
                end else begin
                    hazard = 1'b1;
                end
            end else if (ex2_pending_i && ex2_rd_i == rs) begin
                if (ex2_data_valid_i) begin
                    value = ex2_data_i;
                end else begin
                    hazard = 1'b1;
                end
            end
        end
        return {hazard, value};
    endfunction

    always_comb begin
        // rs2 is checked even for immediate forms, which only costs a stall
        {rs1_hazard, rs1_value_o} = bypass(head_rs1_i, ra_data_i);
        {rs2_hazard, rs2_value_o} = bypass(head_rs2_i, rb_data_i);

        struct_hazard = !ex1_ready_i ||
                        (unit_of_op(head_op_i) == FU_MUL && !mul_ready_i);

        issue_o = head_valid_i && !rs1_hazard && !rs2_hazard && !struct_hazard;
    end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exec_pkg::op_e    op_i,
    input  exec_pkg::xlen_t  operand_a_i,
    input  exec_pkg::xlen_t  operand_b_i,
    output exec_pkg::xlen_t  result_o
);

    import exec_pkg::*;

    localparam int MSB = $bits(xlen_t) - 1;

    xlen_t        sum;
    logic [MSB+1:0] difference;
    logic [4:0]   shamt;
    logic         lt_signed;
    logic         lt_unsigned;

    assign sum        = operand_a_i + operand_b_i;
    // Extra bit on the subtractor gives the unsigned borrow
    assign difference = {1'b0, operand_a_i} - {1'b0, operand_b_i};
    assign shamt      = operand_b_i[4:0];

    assign lt_unsigned = difference[MSB+1];
    // Signs differ, so a negative A is the smaller one
    assign lt_signed   = (operand_a_i[MSB] != operand_b_i[MSB]) ? operand_a_i[MSB]
                                                                 : difference[MSB];

    always_comb begin
        unique case (op_i)
            OP_ADD:  result_o = sum;
            OP_SUB:  result_o = difference[MSB:0];
            OP_AND:  result_o = operand_a_i & operand_b_i;
            OP_OR:   result_o = operand_a_i | operand_b_i;
            OP_XOR:  result_o = operand_a_i ^ operand_b_i;
            OP_SLL:  result_o = operand_a_i << shamt;
            OP_SRL:  result_o = operand_a_i >> shamt;
            OP_SRA:  result_o = xlen_t'($signed(operand_a_i) >>> shamt);
            OP_SLT:  result_o = {{MSB{1'b0}}, lt_signed};
            OP_SLTU: result_o = {{MSB{1'b0}}, lt_unsigned};
            // Multiplies belong to the multiplier
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module mul_unit (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             mul_valid_i,
    input  exec_pkg::xlen_t  operand_a_i,
    input  exec_pkg::xlen_t  operand_b_i,
    output logic             mul_ready_o,
    output logic             mul_valid_o,
    output exec_pkg::xlen_t  mul_data_o
);

    import exec_pkg::*;

    localparam int CNT_W = $clog2(`EXEC_MUL_LATENCY + 1);

    logic             busy_q;
    logic [CNT_W-1:0] count_q;
    xlen_t            product_q;
    logic             accept;

    assign mul_valid_o = busy_q && (count_q == '0);
    // Single slot, a new operation may enter while the old result leaves
    assign mul_ready_o = !busy_q || mul_valid_o;
    assign accept      = mul_valid_i && mul_ready_o;
    assign mul_data_o  = product_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            count_q <= '0;
        end else if (accept) begin
            busy_q  <= 1'b1;
            count_q <= CNT_W'(`EXEC_MUL_LATENCY);
        end else begin
            if (mul_valid_o) begin
                busy_q <= 1'b0;
            end
            if (count_q != '0) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Low XLEN bits of the unsigned product
    always_ff @(posedge clk_i) begin
        if (accept) begin
            product_q <= operand_a_i * operand_b_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ex_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_pipeline (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                issue_i,
    input  exec_pkg::op_e       issue_op_i,
    input  exec_pkg::reg_idx_t  issue_rd_i,
    input  exec_pkg::xlen_t     alu_result_i,
    input  logic                mul_valid_i,
    input  exec_pkg::xlen_t     mul_data_i,
    output logic                ex1_pending_o,
    output logic                ex1_data_valid_o,
    output exec_pkg::reg_idx_t  ex1_rd_o,
    output exec_pkg::xlen_t     ex1_data_o,
    output logic                ex2_pending_o,
    output logic                ex2_data_valid_o,
    output exec_pkg::reg_idx_t  ex2_rd_o,
    output exec_pkg::xlen_t     ex2_data_o,
    output logic                ex1_ready_o,
    output logic                wb_valid_o,
    output exec_pkg::reg_idx_t  wb_rd_o,
    output exec_pkg::xlen_t     wb_data_o
);

    import exec_pkg::*;

    logic       ex1_pending_q, ex1_pending_d;
    func_unit_e ex1_select_q, ex1_select_d;
    reg_idx_t   ex1_rd_q, ex1_rd_d;
    xlen_t      ex1_alu_q, ex1_alu_d;
    logic       ex1_data_valid;
    xlen_t      ex1_data;

    logic       ex2_pending_q, ex2_pending_d;
    func_unit_e ex2_select_q, ex2_select_d;
    reg_idx_t   ex2_rd_q, ex2_rd_d;
    xlen_t      ex2_alu_q, ex2_alu_d;
    logic       ex2_data_valid;
    xlen_t      ex2_data;

    logic       ex2_ready;

    assign ex2_ready   = !ex2_pending_q || ex2_data_valid;
    assign ex1_ready_o = ex2_ready || !ex1_pending_q;

    ////////////////////
    // EX1 stage
    ////////////////////

    // A multiplier result belongs to EX2 if EX2 is the one waiting on it
    always_comb begin
        unique case (ex1_select_q)
            FU_MUL: begin
                ex1_data_valid = mul_valid_i && ex2_select_q != FU_MUL;
                ex1_data       = mul_data_i;
            end
            default: begin
                ex1_data_valid = 1'b1;
                ex1_data       = ex1_alu_q;
            end
        endcase
    end

    always_comb begin
        ex1_pending_d = ex1_pending_q;
        ex1_select_d  = ex1_select_q;
        ex1_rd_d      = ex1_rd_q;
        ex1_alu_d     = ex1_alu_q;

        // Keep a finished result while EX2 is still busy
        if (ex1_data_valid) begin
            ex1_select_d = FU_ALU;
            ex1_alu_d    = ex1_data;
        end

        if (ex2_ready) begin
            ex1_pending_d = 1'b0;
            ex1_select_d  = FU_ALU;
            ex1_rd_d      = '0;
        end

        if (issue_i) begin
            ex1_pending_d = 1'b1;
            ex1_select_d  = unit_of_op(issue_op_i);
            ex1_rd_d      = issue_rd_i;
            ex1_alu_d     = alu_result_i;
        end
    end

    ////////////////////
    // EX2 stage
    ////////////////////

    always_comb begin
        unique case (ex2_select_q)
            FU_MUL: begin
                ex2_data_valid = mul_valid_i;
                ex2_data       = mul_data_i;
            end
            default: begin
                ex2_data_valid = 1'b1;
                ex2_data       = ex2_alu_q;
            end
        endcase
    end

    always_comb begin
        ex2_pending_d = ex2_pending_q;
        ex2_select_d  = ex2_select_q;
        ex2_rd_d      = ex2_rd_q;
        ex2_alu_d     = ex2_alu_q;

        // Retired this cycle
        if (ex2_data_valid) begin
            ex2_pending_d = 1'b0;
            ex2_select_d  = FU_ALU;
            ex2_rd_d      = '0;
        end

        if (ex1_pending_q && ex2_ready) begin
            ex2_pending_d = 1'b1;
            ex2_rd_d      = ex1_rd_q;
            ex2_alu_d     = ex1_data;
            ex2_select_d  = ex1_data_valid ? FU_ALU : ex1_select_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex1_pending_q <= 1'b0;
            ex1_select_q  <= FU_ALU;
            ex1_rd_q      <= '0;
            ex2_pending_q <= 1'b0;
            ex2_select_q  <= FU_ALU;
            ex2_rd_q      <= '0;
        end else begin
            ex1_pending_q <= ex1_pending_d;
            ex1_select_q  <= ex1_select_d;
            ex1_rd_q      <= ex1_rd_d;
            ex2_pending_q <= ex2_pending_d;
            ex2_select_q  <= ex2_select_d;
            ex2_rd_q      <= ex2_rd_d;
        end
    end

    always_ff @(posedge clk_i) begin
        ex1_alu_q <= ex1_alu_d;
        ex2_alu_q <= ex2_alu_d;
    end

    assign ex1_pending_o    = ex1_pending_q;
    assign ex1_data_valid_o = ex1_data_valid;
    assign ex1_rd_o         = ex1_rd_q;
    assign ex1_data_o       = ex1_data;
    assign ex2_pending_o    = ex2_pending_q;
    assign ex2_data_valid_o = ex2_data_valid;
    assign ex2_rd_o         = ex2_rd_q;
    assign ex2_data_o       = ex2_data;

    // Retirement also feeds the register file write port
    assign wb_valid_o = ex2_pending_q && ex2_data_valid;
    assign wb_rd_o    = ex2_rd_q;
    assign wb_data_o  = ex2_data;

endmodule

`default_nettype wire

// ==== hdl/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                in_valid_i,
    input  exec_pkg::op_e       in_op_i,
    input  exec_pkg::reg_idx_t  in_rd_i,
    input  exec_pkg::reg_idx_t  in_rs1_i,
    input  exec_pkg::reg_idx_t  in_rs2_i,
    input  exec_pkg::xlen_t     in_imm_i,
    input  logic                in_use_imm_i,
    output logic                credit_o,
    output logic                wb_valid_o,
    output exec_pkg::reg_idx_t  wb_rd_o,
    output exec_pkg::xlen_t     wb_data_o
);

    import exec_pkg::*;

    // Queue head
    logic     head_valid;
    op_e      head_op;
    reg_idx_t head_rd;
    reg_idx_t head_rs1;
    reg_idx_t head_rs2;
    xlen_t    head_imm;
    logic     head_use_imm;
    logic     issue;

    // Operands
    xlen_t ra_data;
    xlen_t rb_data;
    xlen_t rs1_value;
    xlen_t rs2_value;
    xlen_t alu_result;

    // Multiplier
    logic  mul_ready;
    logic  mul_valid;
    xlen_t mul_data;

    // Stage state seen by the hazard logic
    logic     ex1_pending;
    logic     ex1_data_valid;
    reg_idx_t ex1_rd;
    xlen_t    ex1_data;
    logic     ex2_pending;
    logic     ex2_data_valid;
    reg_idx_t ex2_rd;
    xlen_t    ex2_data;
    logic     ex1_ready;

    wire xlen_t operand_b = head_use_imm ? head_imm : rs2_value;
    wire logic  mul_start = issue && (head_op == OP_MUL);

    issue_queue u_issue_queue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .in_valid_i     (in_valid_i),
        .in_op_i        (in_op_i),
        .in_rd_i        (in_rd_i),
        .in_rs1_i       (in_rs1_i),
        .in_rs2_i       (in_rs2_i),
        .in_imm_i       (in_imm_i),
        .in_use_imm_i   (in_use_imm_i),
        .issue_i        (issue),
        .head_valid_o   (head_valid),
        .head_op_o      (head_op),
        .head_rd_o      (head_rd),
        .head_rs1_o     (head_rs1),
        .head_rs2_o     (head_rs2),
        .head_imm_o     (head_imm),
        .head_use_imm_o (head_use_imm),
        .credit_o       (credit_o)
    );

    reg_file u_reg_file (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .ra_sel_i  (head_rs1),
        .rb_sel_i  (head_rs2),
        .ra_data_o (ra_data),
        .rb_data_o (rb_data),
        .w_en_i    (wb_valid_o),
        .w_sel_i   (wb_rd_o),
        .w_data_i  (wb_data_o)
    );

    hazard_bypass u_hazard_bypass (
        .head_valid_i     (head_valid),
        .head_op_i        (head_op),
        .head_rs1_i       (head_rs1),
        .head_rs2_i       (head_rs2),
        .ra_data_i        (ra_data),
        .rb_data_i        (rb_data),
        .ex1_pending_i    (ex1_pending),
        .ex1_data_valid_i (ex1_data_valid),
        .ex1_rd_i         (ex1_rd),
        .ex1_data_i       (ex1_data),
        .ex2_pending_i    (ex2_pending),
        .ex2_data_valid_i (ex2_data_valid),
        .ex2_rd_i         (ex2_rd),
        .ex2_data_i       (ex2_data),
        .ex1_ready_i      (ex1_ready),
        .mul_ready_i      (mul_ready),
        .rs1_value_o      (rs1_value),
        .rs2_value_o      (rs2_value),
        .issue_o          (issue)
    );

    alu u_alu (
        .op_i        (head_op),
        .operand_a_i (rs1_value),
        .operand_b_i (operand_b),
        .result_o    (alu_result)
    );

    mul_unit u_mul_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mul_valid_i (mul_start),
        .operand_a_i (rs1_value),
        .operand_b_i (operand_b),
        .mul_ready_o (mul_ready),
        .mul_valid_o (mul_valid),
        .mul_data_o  (mul_data)
    );

    ex_pipeline u_ex_pipeline (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .issue_i          (issue),
        .issue_op_i       (head_op),
        .issue_rd_i       (head_rd),
        .alu_result_i     (alu_result),
        .mul_valid_i      (mul_valid),
        .mul_data_i       (mul_data),
        .ex1_pending_o    (ex1_pending),
        .ex1_data_valid_o (ex1_data_valid),
        .ex1_rd_o         (ex1_rd),
        .ex1_data_o       (ex1_data),
        .ex2_pending_o    (ex2_pending),
        .ex2_data_valid_o (ex2_data_valid),
        .ex2_rd_o         (ex2_rd),
        .ex2_data_o       (ex2_data),
        .ex1_ready_o      (ex1_ready),
        .wb_valid_o       (wb_valid_o),
        .wb_rd_o          (wb_rd_o),
        .wb_data_o        (wb_data_o)
    );

endmodule

`default_nettype wire

// ==== test/tb_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module tb_exec_core;

    import exec_pkg::*;

    localparam int DEPTH          = `EXEC_QUEUE_DEPTH;
    localparam int XLEN           = `EXEC_XLEN;
    localparam int CREDIT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 500;
    localparam int RANDOM_ROWS    = 40;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    op_e      in_op;
    reg_idx_t in_rd;
    reg_idx_t in_rs1;
    reg_idx_t in_rs2;
    xlen_t    in_imm;
    logic     in_use_imm;
    logic     credit_o;
    logic     wb_valid_o;
    reg_idx_t wb_rd_o;
    xlen_t    wb_data_o;

    // Instruction table, one entry per row
    op_e      tab_op[$];
    reg_idx_t tab_rd[$];
    reg_idx_t tab_rs1[$];
    reg_idx_t tab_rs2[$];
    xlen_t    tab_imm[$];
    logic     tab_use_imm[$];

    // Reference state and expected retirements
    xlen_t    ref_regs[`EXEC_NUM_REGS];
    reg_idx_t exp_rd_q[$];
    xlen_t    exp_data_q[$];

    int sent;
    int retired;
    int credits_returned;

    exec_core UUT (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .in_valid_i   (in_valid),
        .in_op_i      (in_op),
        .in_rd_i      (in_rd),
        .in_rs1_i     (in_rs1),
        .in_rs2_i     (in_rs2),
        .in_imm_i     (in_imm),
        .in_use_imm_i (in_use_imm),
        .credit_o     (credit_o),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    always #20 clk = ~clk;

    ////////////////////
    // Checks
    ////////////////////

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic fail_with(string reason);
        $display("ERROR: %s", reason);
        stop_run();
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_rd(string name, reg_idx_t actual, reg_idx_t expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_data(string name, xlen_t actual, xlen_t expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            stop_run();
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic xlen_t model_result(op_e op, xlen_t a, xlen_t b);
        logic signed [XLEN-1:0] a_signed;
        logic [2*XLEN-1:0]      product;
        a_signed = a;
        product  = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return xlen_t'(a_signed >>> b[4:0]);
            OP_SLT:  return ($signed(a) < $signed(b)) ? xlen_t'(1) : xlen_t'(0);
            OP_SLTU: return (a < b) ? xlen_t'(1) : xlen_t'(0);
            // Only the low half of the product is kept
            OP_MUL:  return product[XLEN-1:0];
            default: return '0;
        endcase
    endfunction

    task automatic add_row(op_e op, int rd, int rs1, int rs2, xlen_t imm, logic use_imm);
        tab_op.push_back(op);
        tab_rd.push_back(reg_idx_t'(rd));
        tab_rs1.push_back(reg_idx_t'(rs1));
        tab_rs2.push_back(reg_idx_t'(rs2));
        tab_imm.push_back(imm);
        tab_use_imm.push_back(use_imm);
    endtask

    // Drives one row and runs it on the reference registers
    task automatic send_row(int i);
        xlen_t a;
        xlen_t b;
        xlen_t result;
        in_valid   = 1'b1;
        in_op      = tab_op[i];
        in_rd      = tab_rd[i];
        in_rs1     = tab_rs1[i];
        in_rs2     = tab_rs2[i];
        in_imm     = tab_imm[i];
        in_use_imm = tab_use_imm[i];
        a      = (tab_rs1[i] == '0) ? '0 : ref_regs[tab_rs1[i]];
        b      = tab_use_imm[i] ? tab_imm[i] :
                 (tab_rs2[i] == '0) ? '0 : ref_regs[tab_rs2[i]];
        result = model_result(tab_op[i], a, b);
        exp_rd_q.push_back(tab_rd[i]);
        exp_data_q.push_back(result);
        if (tab_rd[i] != '0) begin
            ref_regs[tab_rd[i]] = result;
        end
        sent++;
    endtask

    task automatic drive_idle();
        in_valid = 1'b0;
    endtask

    ////////////////////
    // Monitor
    ////////////////////

    always @(posedge clk) begin
        if (credit_o) begin
            credits_returned++;
            if (credits_returned > sent) begin
                fail_with("credit returned with no instruction outstanding");
            end
        end
        if (wb_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                fail_with("retirement seen with no instruction outstanding");
            end else begin
                check_rd("wb_rd_o", wb_rd_o, exp_rd_q.pop_front());
                check_data("wb_data_o", wb_data_o, exp_data_q.pop_front());
                retired++;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        int          gap;
        int          waited;
        logic [3:0]  op_bits;

        void'($urandom(31161));
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_op      = OP_ADD;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_imm     = '0;
        in_use_imm = 1'b0;
        sent             = 0;
        retired          = 0;
        credits_returned = 0;
        for (int r = 0; r < `EXEC_NUM_REGS; r++) begin
            ref_regs[r] = '0;
        end

        // Independent ALU and immediate forms
        add_row(OP_ADD, 1, 0, 0, 32'h1234_5678, 1'b1);
        add_row(OP_ADD, 2, 0, 0, 32'hFFFF_0F0F, 1'b1);
        add_row(OP_ADD, 3, 0, 0, 32'h0000_0005, 1'b1);
        add_row(OP_ADD, 4, 0, 0, 32'h8000_0000, 1'b1);
        add_row(OP_SUB, 5, 1, 2, '0, 1'b0);
        add_row(OP_AND, 6, 1, 2, '0, 1'b0);
        add_row(OP_OR, 7, 1, 2, '0, 1'b0);
        add_row(OP_XOR, 8, 1, 2, '0, 1'b0);
        add_row(OP_SLL, 9, 1, 0, 32'h0000_0004, 1'b1);
        add_row(OP_SRL, 10, 4, 3, '0, 1'b0);
        add_row(OP_SRA, 11, 4, 3, '0, 1'b0);
        add_row(OP_SLT, 12, 4, 3, '0, 1'b0);
        add_row(OP_SLTU, 13, 4, 3, '0, 1'b0);
        add_row(OP_SLT, 14, 3, 0, 32'hFFFF_FFFF, 1'b1);
        // Dependent chain through EX1 and EX2
        add_row(OP_ADD, 15, 1, 0, 32'h0000_0001, 1'b1);
        add_row(OP_ADD, 15, 15, 0, 32'h0000_0001, 1'b1);
        add_row(OP_ADD, 16, 15, 15, '0, 1'b0);
        add_row(OP_SUB, 17, 16, 1, '0, 1'b0);
        add_row(OP_XOR, 15, 17, 16, '0, 1'b0);
        // Multiplies, back to back and feeding the ALU
        add_row(OP_MUL, 18, 1, 2, '0, 1'b0);
        add_row(OP_MUL, 19, 18, 3, '0, 1'b0);
        add_row(OP_MUL, 20, 2, 2, '0, 1'b0);
        add_row(OP_ADD, 21, 19, 20, '0, 1'b0);
        add_row(OP_MUL, 22, 21, 0, 32'h0000_0007, 1'b1);
        add_row(OP_SLL, 23, 22, 0, 32'h0000_0003, 1'b1);
        // x0 stays zero
        add_row(OP_ADD, 0, 1, 0, 32'h0000_0064, 1'b1);
        add_row(OP_ADD, 24, 0, 0, '0, 1'b0);
        add_row(OP_MUL, 0, 1, 1, '0, 1'b0);
        add_row(OP_OR, 25, 0, 3, '0, 1'b0);
        for (int r = 0; r < RANDOM_ROWS; r++) begin
            op_bits = 4'($urandom % 11);
            add_row(op_e'(op_bits), $urandom % 32, $urandom % 32, $urandom % 32,
                    $urandom, 1'($urandom % 2));
        end

        // Outputs stay quiet through reset and just after it
        repeat (4) begin
            @(posedge clk);
            check_flag("credit_o", credit_o, 1'b0);
            check_flag("wb_valid_o", wb_valid_o, 1'b0);
        end
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge clk);
            check_flag("credit_o", credit_o, 1'b0);
            check_flag("wb_valid_o", wb_valid_o, 1'b0);
        end

        for (int i = 0; i < tab_op.size(); i++) begin
            // Mostly back to back so the credits run out
            gap = (($urandom % 4) == 0) ? ($urandom % 5) : 0;
            repeat (gap) begin
                @(negedge clk);
                drive_idle();
            end
            @(negedge clk);
            waited = 0;
            while (sent - credits_returned >= DEPTH) begin
                drive_idle();
                waited++;
                if (waited > CREDIT_TIMEOUT) begin
                    fail_with("timed out waiting for a credit");
                end
                @(negedge clk);
            end
            send_row(i);
        end
        @(negedge clk);
        drive_idle();

        waited = 0;
        while (retired < sent || credits_returned < sent) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                fail_with("timed out waiting for all instructions to retire");
            end
            @(negedge clk);
        end
        // A few quiet cycles catch any extra retirement
        repeat (10) @(negedge clk);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/exec_pkg.sv
hdl/issue_queue.sv
hdl/reg_file.sv
hdl/hazard_bypass.sv
hdl/alu.sv
hdl/mul_unit.sv
hdl/ex_pipeline.sv
hdl/exec_core.sv
test/tb_exec_core.sv
